/* design/vex_pkg.sv */
// shared definitions for the two-lane vector execute stage
//   data, product and write-control types
//   functional unit, ALU, min/max, SEW and operand source encodings
//   lane word union and the SEW-aware signed compare
`default_nettype none

package vex_pkg;

  typedef logic [31:0] word_t;
  typedef logic [63:0] product_t;
  typedef logic [4:0]  offset_t;
  typedef logic [1:0]  wen_t;

  // one lane word seen as a word, two halfwords or four bytes
  typedef union packed {
    word_t            w;
    logic [1:0][15:0] h;
    logic [3:0][7:0]  b;
  } elem_word_u;

  typedef enum logic {
    FU_ALU = 1'b0,
    FU_MUL = 1'b1
  } fu_t;

  // codes 3'b111 not used
  typedef enum logic [2:0] {
    VALU_ADD  = 3'd0,
    VALU_SUB  = 3'd1,
    VALU_AND  = 3'd2,
    VALU_OR   = 3'd3,
    VALU_XOR  = 3'd4,
    VALU_MM   = 3'd5,
    VALU_PASS = 3'd6
  } aluop_t;

  typedef enum logic [1:0] {
    MIN  = 2'd0,
    MINU = 2'd1,
    MAX  = 2'd2,
    MAXU = 2'd3
  } minmax_t;

  typedef enum logic [1:0] {
    SEW8  = 2'd0,
    SEW16 = 2'd1,
    SEW32 = 2'd2
  } sew_t;

  typedef enum logic [1:0] {
    SRC_V    = 2'd0,
    SRC_I    = 2'd1,
    SRC_X    = 2'd2,
    SRC_NONE = 2'd3
  } src_t;

  // easy to spot in a waveform
  localparam word_t BAD_REDUCTION = 32'hbad0_bad0;

  // signed x < y, taken on the low element of width sew
  function automatic logic sew_signed_lt(word_t x, word_t y, sew_t sew);
    elem_word_u xu;
    elem_word_u yu;
    logic       lt;
    xu = x;
    yu = y;
    case (sew)
      SEW8:    lt = $signed(xu.b[0]) < $signed(yu.b[0]);
      SEW16:   lt = $signed(xu.h[0]) < $signed(yu.h[0]);
      default: lt = $signed(xu.w) < $signed(yu.w);
    endcase
    return lt;
  endfunction

endpackage

`default_nettype wire

/* design/latency_timer.sv */
// latency timer for the multiply sequencer
//   loadable down-counter, flags the last cycle of a programmed latency
`timescale 1ns/10ps
`default_nettype none

module latency_timer #(
  parameter int MUL_STAGES = 3
) (
  input  logic CLK,
  input  logic nRST,
  input  logic load,
  input  logic clear,
  output logic expired
);

  localparam int CNT_W = $clog2(MUL_STAGES + 1);

  logic [CNT_W-1:0] count;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      count <= '0;
    end else if (clear) begin
      count <= '0;
    end else if (load) begin
      count <= CNT_W'(MUL_STAGES);
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

  // count hits zero at the next edge
  assign expired = (count == CNT_W'(1));

endmodule

`default_nettype wire

/* design/mul_sequencer.sv */
// multiply sequencer
//   two-state FSM, one multiply in flight at a time
//   holds the write enables and offsets until the product is ready
//   busy toward hazard control, done pulse toward the result latch
`timescale 1ns/10ps
`default_nettype none

module mul_sequencer #(
  parameter int MUL_STAGES = 3
) (
  input  logic             CLK,
  input  logic             nRST,
  input  logic             start_mul,
  input  logic             flush,
  input  vex_pkg::wen_t    wen_in,
  input  vex_pkg::offset_t woffset0_in,
  input  vex_pkg::offset_t woffset1_in,
  output logic             mul_start,
  output logic             busy,
  output logic             mul_done,
  output vex_pkg::wen_t    wen_hold,
  output vex_pkg::offset_t woffset0_hold,
  output vex_pkg::offset_t woffset1_hold
);

  typedef enum logic {
    IDLE = 1'b0,
    BUSY = 1'b1
  } state_t;

  state_t state, next_state;
  logic   expired;

  // flush beats a new multiply
  assign mul_start = (state == IDLE) & start_mul & ~flush;
  assign busy      = (state == BUSY);

  latency_timer #(
    .MUL_STAGES(MUL_STAGES)
  ) u_timer (
    .CLK     (CLK),
    .nRST    (nRST),
    .load    (mul_start),
    .clear   (flush),
    .expired (expired)
  );

  always_comb begin
    next_state = state;
    if (flush) begin
      next_state = IDLE;
    end else if (state == IDLE && start_mul) begin
      next_state = BUSY;
    end else if (state == BUSY && expired) begin
      next_state = IDLE;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state    <= IDLE;
      mul_done <= 1'b0;
    end else begin
      state    <= next_state;
      // product lands one cycle after the last busy cycle
      mul_done <= ~flush & (state == BUSY) & expired;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wen_hold      <= '0;
      woffset0_hold <= '0;
      woffset1_hold <= '0;
    end else if (mul_start) begin
      wen_hold      <= wen_in;
      woffset0_hold <= woffset0_in;
      woffset1_hold <= woffset1_in;
    end
  end

endmodule

`default_nettype wire

/* design/lane_multiplier.sv */
// pipelined 32x32 lane multiplier
//   operands, signedness and half select captured on start
//   product carried through MUL_STAGES register stages
//   high or low half chosen after the last stage
`timescale 1ns/10ps
`default_nettype none

module lane_multiplier #(
  parameter int MUL_STAGES = 3
) (
  input  logic           CLK,
  input  logic           nRST,
  input  logic           mul_start,
  input  vex_pkg::word_t a,
  input  vex_pkg::word_t b,
  input  logic           mul_signed,
  input  logic           mul_high,
  output vex_pkg::word_t product_half
);

  import vex_pkg::*;

  word_t                   a_r;
  word_t                   b_r;
  logic                    signed_r;
  logic                    high_r;
  logic signed [32:0]      a_ext;
  logic signed [32:0]      b_ext;
  logic signed [65:0]      full_prod;
  product_t                pipe [MUL_STAGES];
  logic [MUL_STAGES-1:0]   high_pipe;

  always_ff @(posedge CLK) begin
    if (mul_start) begin
      a_r      <= a;
      b_r      <= b;
      signed_r <= mul_signed;
      high_r   <= mul_high;
    end
  end

  // one extra bit so a single signed multiply covers both forms
  assign a_ext     = {signed_r & a_r[31], a_r};
  assign b_ext     = {signed_r & b_r[31], b_r};
  assign full_prod = a_ext * b_ext;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < MUL_STAGES; i++) begin
        pipe[i] <= '0;
      end
      high_pipe <= '0;
    end else begin
      pipe[0]      <= full_prod[63:0];
      high_pipe[0] <= high_r;
      for (int i = 1; i < MUL_STAGES; i++) begin
        pipe[i]      <= pipe[i-1];
        high_pipe[i] <= high_pipe[i-1];
      end
    end
  end

  assign product_half = high_pipe[MUL_STAGES-1] ? pipe[MUL_STAGES-1][63:32]
                                                : pipe[MUL_STAGES-1][31:0];

endmodule

`default_nettype wire

/* design/vector_lane.sv */
// one vector lane
//   operand source select for both ALU ports
//   ALU with add, sub, logic ops, pass and min/max
//   SEW-aware signed compare for min/max
`timescale 1ns/10ps
`default_nettype none

module vector_lane (
  input  vex_pkg::src_t    rs1_src,
  input  vex_pkg::src_t    rs2_src,
  input  vex_pkg::word_t   vs1,
  input  vex_pkg::word_t   vs2,
  input  vex_pkg::word_t   xs1,
  input  vex_pkg::word_t   xs2,
  input  vex_pkg::word_t   imm,
  input  vex_pkg::aluop_t  aluop,
  input  vex_pkg::minmax_t minmax,
  input  vex_pkg::sew_t    sew,
  output vex_pkg::word_t   opa,
  output vex_pkg::word_t   opb,
  output vex_pkg::word_t   alu_result
);

  import vex_pkg::*;

  logic  a_lt_b_s;
  logic  b_lt_a_s;
  logic  a_lt_b_u;
  logic  b_lt_a_u;
  word_t mm_result;

  always_comb begin
    case (rs1_src)
      SRC_V:   opa = vs1;
      SRC_I:   opa = imm;
      SRC_X:   opa = xs1;
      default: opa = '0;
    endcase
  end

  always_comb begin
    case (rs2_src)
      SRC_V:   opb = vs2;
      SRC_I:   opb = imm;
      SRC_X:   opb = xs2;
      default: opb = '0;
    endcase
  end

  // signed forms only look at the low element
  assign a_lt_b_s = sew_signed_lt(opa, opb, sew);
  assign b_lt_a_s = sew_signed_lt(opb, opa, sew);
  assign a_lt_b_u = opa < opb;
  assign b_lt_a_u = opb < opa;

  // whole word selected, ties go to operand a
  always_comb begin
    case (minmax)
      MIN:     mm_result = b_lt_a_s ? opb : opa;
      MINU:    mm_result = b_lt_a_u ? opb : opa;
      MAX:     mm_result = a_lt_b_s ? opb : opa;
      default: mm_result = a_lt_b_u ? opb : opa;
    endcase
  end

  always_comb begin
    case (aluop)
      VALU_ADD:  alu_result = opa + opb;
      // vs2 side is the minuend
      VALU_SUB:  alu_result = opb - opa;
      VALU_AND:  alu_result = opa & opb;
      VALU_OR:   alu_result = opa | opb;
      VALU_XOR:  alu_result = opa ^ opb;
      VALU_MM:   alu_result = mm_result;
      VALU_PASS: alu_result = opb;
      default:   alu_result = '0;
    endcase
  end

endmodule

`default_nettype wire

/* design/reduction_combiner.sv */
// reduction combiner
//   joins the two lane results for reduction instructions
//   min/max follows the same SEW rule as the lanes
`timescale 1ns/10ps
`default_nettype none

module reduction_combiner (
  input  vex_pkg::word_t   r0,
  input  vex_pkg::word_t   r1,
  input  vex_pkg::aluop_t  aluop,
  input  vex_pkg::minmax_t minmax,
  input  vex_pkg::sew_t    sew,
  output vex_pkg::word_t   combined
);

  import vex_pkg::*;

  logic  r1_lt_r0_s;
  logic  r0_lt_r1_s;
  word_t mm_result;

  assign r1_lt_r0_s = sew_signed_lt(r1, r0, sew);
  assign r0_lt_r1_s = sew_signed_lt(r0, r1, sew);

  // equal results keep r0
  always_comb begin
    case (minmax)
      MIN:     mm_result = r1_lt_r0_s ? r1 : r0;
      MINU:    mm_result = (r1 < r0) ? r1 : r0;
      MAX:     mm_result = r0_lt_r1_s ? r1 : r0;
      default: mm_result = (r0 < r1) ? r1 : r0;
    endcase
  end

  always_comb begin
    case (aluop)
      VALU_ADD: combined = r0 + r1;
      VALU_AND: combined = r0 & r1;
      VALU_OR:  combined = r0 | r1;
      VALU_XOR: combined = r0 ^ r1;
      VALU_MM:  combined = mm_result;
      // sub, pass and spare codes have no reduction form
      default:  combined = BAD_REDUCTION;
    endcase
  end

endmodule

`default_nettype wire

/* design/vector_execute_stage.sv */
// two-lane vector execute stage
//   two lanes with their multipliers
//   multiply sequencer and reduction combiner
//   result latch toward the memory stage, with stall and flush
`timescale 1ns/10ps
`default_nettype none

module vector_execute_stage #(
  parameter int MUL_STAGES = 3
) (
  input  logic             CLK,
  input  logic             nRST,
  input  logic             issue,
  input  vex_pkg::fu_t     fu,
  input  vex_pkg::aluop_t  aluop,
  input  vex_pkg::minmax_t minmax,
  input  vex_pkg::sew_t    sew,
  input  vex_pkg::src_t    rs1_src,
  input  vex_pkg::src_t    rs2_src,
  input  vex_pkg::word_t   vs1_lane0,
  input  vex_pkg::word_t   vs1_lane1,
  input  vex_pkg::word_t   vs2_lane0,
  input  vex_pkg::word_t   vs2_lane1,
  input  vex_pkg::word_t   xs1,
  input  vex_pkg::word_t   xs2,
  input  vex_pkg::word_t   imm,
  input  logic             reduction_ena,
  input  logic             mul_signed,
  input  logic             mul_high,
  input  vex_pkg::wen_t    wen,
  input  vex_pkg::offset_t woffset0,
  input  vex_pkg::offset_t woffset1,
  input  logic             stall,
  input  logic             flush,
  output logic             busy,
  output logic             out_valid,
  output vex_pkg::word_t   result0,
  output vex_pkg::word_t   result1,
  output vex_pkg::wen_t    out_wen,
  output vex_pkg::offset_t out_woffset0,
  output vex_pkg::offset_t out_woffset1
);

  import vex_pkg::*;

  word_t   opa0, opb0, opa1, opb1;
  word_t   alu0, alu1;
  word_t   prod0, prod1;
  word_t   combined;
  logic    alu_accept;
  logic    mul_start;
  logic    mul_done;
  wen_t    wen_hold;
  offset_t woffset0_hold;
  offset_t woffset1_hold;

  assign alu_accept = issue & (fu == FU_ALU) & ~stall;

  vector_lane u_lane0 (
    .rs1_src (rs1_src),  .rs2_src (rs2_src),
    .vs1     (vs1_lane0), .vs2     (vs2_lane0),
    .xs1     (xs1),      .xs2     (xs2),      .imm    (imm),
    .aluop   (aluop),    .minmax  (minmax),   .sew    (sew),
    .opa     (opa0),     .opb     (opb0),     .alu_result (alu0)
  );

  vector_lane u_lane1 (
    .rs1_src (rs1_src),  .rs2_src (rs2_src),
    .vs1     (vs1_lane1), .vs2     (vs2_lane1),
    .xs1     (xs1),      .xs2     (xs2),      .imm    (imm),
    .aluop   (aluop),    .minmax  (minmax),   .sew    (sew),
    .opa     (opa1),     .opb     (opb1),     .alu_result (alu1)
  );

  lane_multiplier #(.MUL_STAGES(MUL_STAGES)) u_mul0 (
    .CLK (CLK), .nRST (nRST), .mul_start (mul_start),
    .a (opa0), .b (opb0), .mul_signed (mul_signed), .mul_high (mul_high),
    .product_half (prod0)
  );

  lane_multiplier #(.MUL_STAGES(MUL_STAGES)) u_mul1 (
    .CLK (CLK), .nRST (nRST), .mul_start (mul_start),
    .a (opa1), .b (opb1), .mul_signed (mul_signed), .mul_high (mul_high),
    .product_half (prod1)
  );

  mul_sequencer #(.MUL_STAGES(MUL_STAGES)) u_seq (
    .CLK           (CLK),
    .nRST          (nRST),
    .start_mul     (issue & (fu == FU_MUL)),
    .flush         (flush),
    .wen_in        (wen),
    .woffset0_in   (woffset0),
    .woffset1_in   (woffset1),
    .mul_start     (mul_start),
    .busy          (busy),
    .mul_done      (mul_done),
    .wen_hold      (wen_hold),
    .woffset0_hold (woffset0_hold),
    .woffset1_hold (woffset1_hold)
  );

  reduction_combiner u_red (
    .r0 (alu0), .r1 (alu1), .aluop (aluop), .minmax (minmax), .sew (sew),
    .combined (combined)
  );

  // result latch, flush first, then a finished multiply, then the ALU
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      out_valid    <= 1'b0;
      result0      <= '0;
      result1      <= '0;
      out_wen      <= '0;
      out_woffset0 <= '0;
      out_woffset1 <= '0;
    end else if (flush) begin
      out_valid    <= 1'b0;
      result0      <= '0;
      result1      <= '0;
      out_wen      <= '0;
      out_woffset0 <= '0;
      out_woffset1 <= '0;
    end else if (mul_done) begin
      out_valid    <= 1'b1;
      result0      <= prod0;
      result1      <= prod1;
      out_wen      <= wen_hold;
      out_woffset0 <= woffset0_hold;
      out_woffset1 <= woffset1_hold;
    end else if (alu_accept) begin
      out_valid    <= 1'b1;
      result0      <= reduction_ena ? combined : alu0;
      result1      <= alu1;
      out_wen      <= wen;
      out_woffset0 <= woffset0;
      out_woffset1 <= woffset1;
    end else begin
      // data holds, valid is a one-cycle pulse
      out_valid    <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* bench/tb_vector_execute_stage.sv */
// testbench for the two-lane vector execute stage
//   table of instructions applied in a loop
//   reference model for lanes, reductions and multiplies
//   LFSR operand source and a watchdog
`timescale 1ns/10ps
`default_nettype none

module tb_vector_execute_stage;

  import vex_pkg::*;

  localparam int MUL_STAGES = 3;
  localparam int NROWS      = 28;
  localparam int PERIOD     = 20;

  typedef struct packed {
    fu_t     fu;
    aluop_t  op;
    minmax_t mm;
    sew_t    sew;
    src_t    s1;
    src_t    s2;
    logic    red;
    logic    msigned;
    logic    mhigh;
    logic    stall;
    logic    flush;
    logic    rnd;
  } row_t;

  logic    CLK, nRST, issue, reduction_ena, mul_signed, mul_high, stall, flush;
  fu_t     fu;
  aluop_t  aluop;
  minmax_t minmax;
  sew_t    sew;
  src_t    rs1_src, rs2_src;
  word_t   vs1_lane0, vs1_lane1, vs2_lane0, vs2_lane1, xs1, xs2, imm;
  wen_t    wen;
  offset_t woffset0, woffset1;
  logic    busy, out_valid;
  word_t   result0, result1;
  wen_t    out_wen;
  offset_t out_woffset0, out_woffset1;

  row_t        rows [NROWS];
  int          nfill;
  logic [15:0] lfsr;
  int          row_errors;
  int          passed;
  int          failed;
  word_t       exp_r0, exp_r1;
  wen_t        exp_wen;
  offset_t     exp_o0, exp_o1;

  vector_execute_stage UUT (.*);

  initial begin
    CLK = 1'b0;
    forever #(PERIOD / 2) CLK = ~CLK;
  end

  // budget of MUL_STAGES+4 cycles per row plus reset
  initial begin
    #((5 + NROWS * (MUL_STAGES + 4)) * PERIOD);
    $display("watchdog expired before all rows finished");
    $display("TESTBENCH FAILED");
    $finish;
  end

  // 16-bit Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_word(output word_t w);
    w = '0;
    for (int i = 0; i < 32; i++) begin
      lfsr = lfsr_next(lfsr);
      w = {w[30:0], lfsr[0]};
    end
  endtask

  function automatic word_t pick(src_t src, word_t v, word_t x, word_t i);
    case (src)
      SRC_V:   return v;
      SRC_I:   return i;
      SRC_X:   return x;
      default: return '0;
    endcase
  endfunction

  // sign-extend the low element and compare as 32-bit signed
  function automatic logic slt(word_t x, word_t y, sew_t s);
    int                 sh;
    logic signed [31:0] xe;
    logic signed [31:0] ye;
    sh = (s == SEW8) ? 24 : (s == SEW16) ? 16 : 0;
    xe = $signed(x << sh) >>> sh;
    ye = $signed(y << sh) >>> sh;
    return xe < ye;
  endfunction

  function automatic word_t minmax_ref(word_t a, word_t b, minmax_t m, sew_t s);
    case (m)
      MIN:     return slt(b, a, s) ? b : a;
      MINU:    return (b < a) ? b : a;
      MAX:     return slt(a, b, s) ? b : a;
      default: return (a < b) ? b : a;
    endcase
  endfunction

  function automatic word_t alu_ref(word_t a, word_t b, aluop_t op, minmax_t m, sew_t s);
    case (op)
      VALU_ADD:  return a + b;
      VALU_SUB:  return b - a;
      VALU_AND:  return a & b;
      VALU_OR:   return a | b;
      VALU_XOR:  return a ^ b;
      VALU_MM:   return minmax_ref(a, b, m, s);
      VALU_PASS: return b;
      default:   return '0;
    endcase
  endfunction

  function automatic word_t reduce_ref(word_t r0, word_t r1, aluop_t op, minmax_t m, sew_t s);
    case (op)
      VALU_ADD: return r0 + r1;
      VALU_AND: return r0 & r1;
      VALU_OR:  return r0 | r1;
      VALU_XOR: return r0 ^ r1;
      VALU_MM:  return minmax_ref(r0, r1, m, s);
      default:  return BAD_REDUCTION;
    endcase
  endfunction

  function automatic word_t mul_ref(word_t a, word_t b, logic sgn, logic high);
    logic [63:0] p;
    if (sgn) begin
      p = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
    end else begin
      p = {32'd0, a} * {32'd0, b};
    end
    return high ? p[63:32] : p[31:0];
  endfunction

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("MISMATCH t=%0t %s expected %h got %h", $time, name, exp, act);
      row_errors++;
    end
  endtask

  task automatic check_wen(input string name, input wen_t exp, input wen_t act);
    if (act !== exp) begin
      $display("MISMATCH t=%0t %s expected %b got %b", $time, name, exp, act);
      row_errors++;
    end
  endtask

  task automatic check_offset(input string name, input offset_t exp, input offset_t act);
    if (act !== exp) begin
      $display("MISMATCH t=%0t %s expected %0d got %0d", $time, name, exp, act);
      row_errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("MISMATCH t=%0t %s expected %b got %b", $time, name, exp, act);
      row_errors++;
    end
  endtask

  task automatic check_outputs();
    check_word("result0", exp_r0, result0);
    check_word("result1", exp_r1, result1);
    check_wen("out_wen", exp_wen, out_wen);
    check_offset("out_woffset0", exp_o0, out_woffset0);
    check_offset("out_woffset1", exp_o1, out_woffset1);
  endtask

  task automatic set_expected(input word_t r0, input word_t r1, input wen_t w,
                              input offset_t o0, input offset_t o1);
    exp_r0  = r0;
    exp_r1  = r1;
    exp_wen = w;
    exp_o0  = o0;
    exp_o1  = o1;
  endtask

  task automatic report(input string label);
    if (row_errors == 0) begin
      passed++;
      $display("%s passed", label);
    end else begin
      failed++;
      $display("%s failed with %0d errors", label, row_errors);
    end
  endtask

  // flag bits are reduction, mul signed, mul high, stall, flush and random operands
  task automatic add_row(input fu_t f, input aluop_t op, input minmax_t mm, input sew_t s,
                         input src_t s1, input src_t s2, input logic [5:0] flags);
    rows[nfill] = {f, op, mm, s, s1, s2, flags};
    nfill++;
  endtask

  task automatic load_operands(input logic rnd);
    if (rnd) begin
      rand_word(vs1_lane0);
      rand_word(vs2_lane0);
      rand_word(vs1_lane1);
      rand_word(vs2_lane1);
      rand_word(xs1);
      rand_word(xs2);
      rand_word(imm);
    end else begin
      // byte, halfword and word orderings disagree
      vs1_lane0 = 32'h8000_0080;
      vs2_lane0 = 32'h0000_8001;
      vs1_lane1 = 32'h0000_ff7f;
      vs2_lane1 = 32'hffff_0001;
      xs1       = 32'h0000_0180;
      xs2       = 32'h7fff_ff80;
      imm       = 32'hffff_ff7f;
    end
  endtask

  task automatic run_row(input int n);
    row_t    r;
    word_t   a0, b0, a1, b1, l0, l1;
    wen_t    w_wen;
    offset_t w_o0, w_o1;
    int      valid_at;
    r = rows[n];
    row_errors = 0;
    @(posedge CLK);
    #2;
    load_operands(r.rnd);
    issue         = 1'b1;
    fu            = r.fu;
    aluop         = r.op;
    minmax        = r.mm;
    sew           = r.sew;
    rs1_src       = r.s1;
    rs2_src       = r.s2;
    reduction_ena = r.red;
    mul_signed    = r.msigned;
    mul_high      = r.mhigh;
    stall         = r.stall;
    flush         = r.flush && (r.fu == FU_ALU);
    wen           = wen_t'(n);
    woffset0      = offset_t'(3 * n);
    woffset1      = offset_t'(31 - n);
    w_wen = wen;
    w_o0  = woffset0;
    w_o1  = woffset1;
    a0 = pick(r.s1, vs1_lane0, xs1, imm);
    b0 = pick(r.s2, vs2_lane0, xs2, imm);
    a1 = pick(r.s1, vs1_lane1, xs1, imm);
    b1 = pick(r.s2, vs2_lane1, xs2, imm);
    l0 = alu_ref(a0, b0, r.op, r.mm, r.sew);
    l1 = alu_ref(a1, b1, r.op, r.mm, r.sew);
    @(posedge CLK);
    #2;
    issue = 1'b0;
    stall = 1'b0;
    if (r.fu == FU_ALU) begin
      flush = 1'b0;
      if (r.flush) begin
        set_expected('0, '0, '0, '0, '0);
      end else if (!r.stall) begin
        set_expected(r.red ? reduce_ref(l0, l1, r.op, r.mm, r.sew) : l0, l1, w_wen, w_o0, w_o1);
      end
      check_bit("out_valid", !r.stall && !r.flush, out_valid);
      check_bit("busy", 1'b0, busy);
    end else begin
      // issue-time controls and operands change under the multiply
      wen        = ~wen;
      woffset0   = ~woffset0;
      woffset1   = ~woffset1;
      vs1_lane0  = ~vs1_lane0;
      vs2_lane1  = ~vs2_lane1;
      xs1        = ~xs1;
      imm        = ~imm;
      mul_signed = ~mul_signed;
      mul_high   = ~mul_high;
      valid_at   = -1;
      for (int k = 0; k <= MUL_STAGES + 2; k++) begin
        check_bit("busy", r.flush ? (k <= 1) : (k < MUL_STAGES), busy);
        if (out_valid) begin
          valid_at = k;
          break;
        end
        flush = r.flush && (k == 1);
        @(posedge CLK);
        #2;
      end
      flush = 1'b0;
      if (r.flush) begin
        if (valid_at >= 0) begin
          $display("row %0d: out_valid pulsed for a flushed multiply", n);
          row_errors++;
        end
        set_expected('0, '0, '0, '0, '0);
      end else if (valid_at < 0) begin
        $display("row %0d: out_valid never pulsed for the multiply", n);
        row_errors++;
      end else begin
        if (valid_at != MUL_STAGES + 1) begin
          $display("MISMATCH t=%0t out_valid delay expected %0d got %0d",
                   $time, MUL_STAGES + 1, valid_at);
          row_errors++;
        end
        set_expected(mul_ref(a0, b0, r.msigned, r.mhigh), mul_ref(a1, b1, r.msigned, r.mhigh),
                     w_wen, w_o0, w_o1);
      end
    end
    check_outputs();
    report($sformatf("row %0d", n));
  endtask

  initial begin
    nRST = 1'b0;
    {issue, reduction_ena, mul_signed, mul_high, stall, flush} = '0;
    fu = FU_ALU;
    aluop = VALU_ADD;
    minmax = MIN;
    sew = SEW32;
    rs1_src = SRC_V;
    rs2_src = SRC_V;
    {vs1_lane0, vs1_lane1, vs2_lane0, vs2_lane1, xs1, xs2, imm} = '0;
    wen = '0;
    woffset0 = '0;
    woffset1 = '0;
    lfsr = 16'd17;
    nfill = 0;
    passed = 0;
    failed = 0;
    set_expected('0, '0, '0, '0, '0);
    add_row(FU_ALU, VALU_ADD,  MIN,  SEW32, SRC_V,    SRC_V,    6'b000001);
    add_row(FU_ALU, VALU_SUB,  MIN,  SEW32, SRC_I,    SRC_V,    6'b000001);
    add_row(FU_ALU, VALU_AND,  MIN,  SEW32, SRC_X,    SRC_X,    6'b000001);
    add_row(FU_ALU, VALU_OR,   MIN,  SEW32, SRC_V,    SRC_NONE, 6'b000001);
    add_row(FU_ALU, VALU_XOR,  MIN,  SEW32, SRC_NONE, SRC_X,    6'b000001);
    add_row(FU_ALU, VALU_PASS, MIN,  SEW32, SRC_X,    SRC_I,    6'b000001);
    add_row(FU_ALU, VALU_MM,   MIN,  SEW8,  SRC_V,    SRC_V,    6'b000000);
    add_row(FU_ALU, VALU_MM,   MIN,  SEW16, SRC_V,    SRC_V,    6'b000000);
    add_row(FU_ALU, VALU_MM,   MIN,  SEW32, SRC_V,    SRC_V,    6'b000000);
    add_row(FU_ALU, VALU_MM,   MAX,  SEW8,  SRC_V,    SRC_V,    6'b000000);
    add_row(FU_ALU, VALU_MM,   MAX,  SEW16, SRC_V,    SRC_V,    6'b000000);
    add_row(FU_ALU, VALU_MM,   MAXU, SEW32, SRC_V,    SRC_V,    6'b000000);
    add_row(FU_ALU, VALU_MM,   MINU, SEW8,  SRC_X,    SRC_I,    6'b000000);
    // reductions
    add_row(FU_ALU, VALU_ADD,  MIN,  SEW32, SRC_V,    SRC_V,    6'b100001);
    add_row(FU_ALU, VALU_XOR,  MIN,  SEW32, SRC_V,    SRC_X,    6'b100001);
    add_row(FU_ALU, VALU_OR,   MIN,  SEW32, SRC_I,    SRC_V,    6'b100001);
    add_row(FU_ALU, VALU_AND,  MIN,  SEW32, SRC_V,    SRC_V,    6'b100001);
    add_row(FU_ALU, VALU_MM,   MAX,  SEW16, SRC_V,    SRC_V,    6'b100000);
    add_row(FU_ALU, VALU_MM,   MIN,  SEW8,  SRC_V,    SRC_V,    6'b100000);
    add_row(FU_ALU, VALU_SUB,  MIN,  SEW32, SRC_V,    SRC_V,    6'b100001);
    // multiplies followed by stall and flush cases
    add_row(FU_MUL, VALU_ADD,  MIN,  SEW32, SRC_V,    SRC_V,    6'b010001);
    add_row(FU_MUL, VALU_ADD,  MIN,  SEW32, SRC_X,    SRC_V,    6'b011001);
    add_row(FU_MUL, VALU_ADD,  MIN,  SEW32, SRC_V,    SRC_V,    6'b000001);
    add_row(FU_MUL, VALU_ADD,  MIN,  SEW32, SRC_V,    SRC_I,    6'b001101);
    add_row(FU_ALU, VALU_ADD,  MIN,  SEW32, SRC_V,    SRC_V,    6'b000101);
    add_row(FU_MUL, VALU_ADD,  MIN,  SEW32, SRC_V,    SRC_V,    6'b010011);
    add_row(FU_ALU, VALU_OR,   MIN,  SEW32, SRC_V,    SRC_V,    6'b000001);
    add_row(FU_ALU, VALU_XOR,  MIN,  SEW32, SRC_V,    SRC_V,    6'b000011);
    repeat (5) @(posedge CLK);
    #2;
    nRST = 1'b1;
    row_errors = 0;
    check_bit("busy", 1'b0, busy);
    check_bit("out_valid", 1'b0, out_valid);
    check_outputs();
    report("reset check");
    for (int n = 0; n < NROWS; n++) begin
      run_row(n);
    end
    $display("%0d tests passed, %0d tests failed", passed, failed);
    if (failed == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
design/vex_pkg.sv
design/latency_timer.sv
design/mul_sequencer.sv
design/lane_multiplier.sv
design/vector_lane.sv
design/reduction_combiner.sv
design/vector_execute_stage.sv
bench/tb_vector_execute_stage.sv
